//--- Bender.yml
package:
  name: proc

sources:
  - logic/procPkg.sv
  - logic/decode.sv
  - logic/execute.sv
  - logic/result.sv
  - logic/proc.sv
  - target: simulation
    files:
      - verification/procAsserts.sv
      - verification/procTb.sv

//--- logic/decode.sv
// Decode stage: decodes the instruction, forwards operands and registers the operation
`timescale 1ns/100ps

module decode import procPkg::*; (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input instrT instr,
	input logic [dataWidth-1:0] rsData,
	input logic [dataWidth-1:0] rtData,
	input writeT exForward,
	input writeT exWrite,
	output regIdxT rsIdx,
	output regIdxT rtIdx,
	output decodedT decoded,
	output logic err
);

	logic legal;
	logic isImm;
	logic signExt;
	aluOpT aluOp;
	regIdxT dest;
	logic [dataWidth-1:0] imm;
	logic [dataWidth-1:0] opA;
	logic [dataWidth-1:0] opB;

	// Youngest producer wins: execute, then writeback, then the file
	function automatic logic [dataWidth-1:0] pickOperand(
		input regIdxT idx,
		input logic [dataWidth-1:0] fileData,
		input writeT fwdEx,
		input writeT fwdWb
	);
		if (fwdEx.valid && fwdEx.dest == idx)
			return fwdEx.data;
		else if (fwdWb.valid && fwdWb.dest == idx)
			return fwdWb.data;
		return fileData;
	endfunction

	// rs sits in the same bits in both layouts
	assign rsIdx = instr.rFmt.rs;
	assign rtIdx = instr.rFmt.rt;

	always_comb begin
		legal = 1'b1;
		isImm = 1'b0;
		signExt = 1'b0;
		aluOp = aluAdd;
		dest = instr.rFmt.rd;
		case (instr.rFmt.opcode)
			opAddi: begin
				isImm = 1'b1;
				signExt = 1'b1;
				aluOp = aluAdd;
			end
			opSubi: begin
				isImm = 1'b1;
				signExt = 1'b1;
				aluOp = aluSub;
			end
			opXori: begin
				isImm = 1'b1;
				aluOp = aluXor;
			end
			opAndni: begin
				isImm = 1'b1;
				aluOp = aluAndn;
			end
			opArith: begin
				case (instr.rFmt.funct)
					fnAdd: aluOp = aluAdd;
					fnSub: aluOp = aluSub;
					fnXor: aluOp = aluXor;
					fnAndn: aluOp = aluAndn;
				endcase
			end
			opShift: begin
				case (instr.rFmt.funct)
					fnRol: aluOp = aluRol;
					fnSll: aluOp = aluSll;
					fnRor: aluOp = aluRor;
					fnSrl: aluOp = aluSrl;
				endcase
			end
			opSet: begin
				case (instr.rFmt.funct)
					fnSeq: aluOp = aluSeq;
					fnSlt: aluOp = aluSlt;
					fnSle: aluOp = aluSle;
					fnSco: aluOp = aluSco;
				endcase
			end
			default: legal = 1'b0;
		endcase
		if (isImm)
			dest = instr.iFmt.rd;
	end

	assign imm = signExt
		? {{(dataWidth-immWidth){instr.iFmt.imm[immWidth-1]}}, instr.iFmt.imm}
		: {{(dataWidth-immWidth){1'b0}}, instr.iFmt.imm};

	assign opA = pickOperand(rsIdx, rsData, exForward, exWrite);
	assign opB = isImm ? imm : pickOperand(rtIdx, rtData, exForward, exWrite);

	// Illegal words leave a bubble behind and pulse err
	always_ff @(posedge clk) begin
		decoded.aluOp <= aluOp;
		decoded.dest <= dest;
		decoded.opA <= opA;
		decoded.opB <= opB;
		if (!rstN) begin
			decoded.valid <= 1'b0;
			err <= 1'b0;
		end else begin
			decoded.valid <= instrValid && legal;
			err <= instrValid && !legal;
		end
	end

endmodule

//--- logic/execute.sv
// Execute stage: single ALU with forwarding output and result register
`timescale 1ns/100ps

module execute import procPkg::*; (
	input logic clk,
	input logic rstN,
	input decodedT decoded,
	output writeT exForward,
	output writeT exWrite
);

	logic [dataWidth-1:0] a;
	logic [dataWidth-1:0] b;
	logic [shiftWidth-1:0] shamt;
	// Extra bit keeps the carry for sco
	logic [dataWidth:0] sum;
	logic [2*dataWidth-1:0] rolWide;
	logic [2*dataWidth-1:0] rorWide;
	logic flag;
	logic [dataWidth-1:0] res;

	assign a = decoded.opA;
	assign b = decoded.opB;
	assign shamt = b[shiftWidth-1:0];
	assign sum = {1'b0, a} + {1'b0, b};

	// Rotates through a doubled word
	assign rolWide = {a, a} << shamt;
	assign rorWide = {a, a} >> shamt;

	always_comb begin
		flag = 1'b0;
		case (decoded.aluOp)
			aluSeq: flag = (a == b);
			aluSlt: flag = ($signed(a) < $signed(b));
			aluSle: flag = ($signed(a) <= $signed(b));
			aluSco: flag = sum[dataWidth];
			default: flag = 1'b0;
		endcase
	end

	always_comb begin
		case (decoded.aluOp)
			aluAdd: res = sum[dataWidth-1:0];
			// Subtract takes operand A from operand B
			aluSub: res = b - a;
			aluXor: res = a ^ b;
			aluAndn: res = a & ~b;
			aluRol: res = rolWide[2*dataWidth-1:dataWidth];
			aluSll: res = a << shamt;
			aluRor: res = rorWide[dataWidth-1:0];
			aluSrl: res = a >> shamt;
			aluSeq, aluSlt, aluSle, aluSco: res = {{(dataWidth-1){1'b0}}, flag};
			default: res = '0;
		endcase
	end

	// Result of the instruction held now, seen by decode
	assign exForward.valid = decoded.valid;
	assign exForward.dest = decoded.dest;
	assign exForward.data = res;

	always_ff @(posedge clk) begin
		exWrite.dest <= exForward.dest;
		exWrite.data <= exForward.data;
		if (!rstN)
			exWrite.valid <= 1'b0;
		else
			exWrite.valid <= exForward.valid;
	end

endmodule

//--- logic/proc.sv
// Pipeline top level connecting the decode, execute and result stages
`timescale 1ns/100ps

module proc import procPkg::*; (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input instrT instr,
	output logic wbValid,
	output regIdxT wbReg,
	output logic [dataWidth-1:0] wbData,
	output logic err
);

	decodedT decoded;
	writeT exForward;
	writeT exWrite;
	writeT rfWrite;
	regIdxT rsIdx;
	regIdxT rtIdx;
	logic [dataWidth-1:0] rsData;
	logic [dataWidth-1:0] rtData;

	decode i_decode (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.rsData(rsData),
		.rtData(rtData),
		.exForward(exForward),
		.exWrite(exWrite),
		.rsIdx(rsIdx),
		.rtIdx(rtIdx),
		.decoded(decoded),
		.err(err)
	);

	execute i_execute (
		.clk(clk),
		.rstN(rstN),
		.decoded(decoded),
		.exForward(exForward),
		.exWrite(exWrite)
	);

	result i_result (
		.clk(clk),
		.rstN(rstN),
		.exWrite(exWrite),
		.rsIdx(rsIdx),
		.rtIdx(rtIdx),
		.rsData(rsData),
		.rtData(rtData),
		.rfWrite(rfWrite)
	);

	assign wbValid = rfWrite.valid;
	assign wbReg = rfWrite.dest;
	assign wbData = rfWrite.data;

endmodule

//--- logic/procPkg.sv
// Shared types and encodings of the three-stage integer pipeline
package procPkg;

	localparam int dataWidth = 16;
	localparam int regCount = 8;
	localparam int immWidth = 5;
	// Shift and rotate amounts come from the low bits of rt
	localparam int shiftWidth = $clog2(dataWidth);

	typedef logic [$clog2(regCount)-1:0] regIdxT;

	// Only these opcodes are legal, all others raise err
	typedef enum logic [4:0] {
		opAddi  = 5'b01000,
		opSubi  = 5'b01001,
		opXori  = 5'b01010,
		opAndni = 5'b01011,
		opShift = 5'b11010,
		opArith = 5'b11011,
		opSet   = 5'b11100
	} opcodeT;

	// Function field, read according to the register-form opcode
	typedef logic [1:0] functT;

	// Arithmetic group
	localparam functT fnAdd  = 2'b00;
	localparam functT fnSub  = 2'b01;
	localparam functT fnXor  = 2'b10;
	localparam functT fnAndn = 2'b11;

	// Shift group
	localparam functT fnRol = 2'b00;
	localparam functT fnSll = 2'b01;
	localparam functT fnRor = 2'b10;
	localparam functT fnSrl = 2'b11;

	// Set group
	localparam functT fnSeq = 2'b00;
	localparam functT fnSlt = 2'b01;
	localparam functT fnSle = 2'b10;
	localparam functT fnSco = 2'b11;

	typedef struct packed {
		opcodeT opcode;
		regIdxT rs;
		regIdxT rt;
		regIdxT rd;
		functT funct;
	} rFormatT;

	typedef struct packed {
		opcodeT opcode;
		regIdxT rs;
		regIdxT rd;
		logic [immWidth-1:0] imm;
	} iFormatT;

	// One instruction word, read in either layout
	typedef union packed {
		rFormatT rFmt;
		iFormatT iFmt;
	} instrT;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluXor, aluAndn,
		aluRol, aluSll, aluRor, aluSrl,
		aluSeq, aluSlt, aluSle, aluSco
	} aluOpT;

	// Operand B already holds the extended immediate for I forms
	typedef struct packed {
		logic valid;
		aluOpT aluOp;
		regIdxT dest;
		logic [dataWidth-1:0] opA;
		logic [dataWidth-1:0] opB;
	} decodedT;

	typedef struct packed {
		logic valid;
		regIdxT dest;
		logic [dataWidth-1:0] data;
	} writeT;

endpackage

//--- logic/result.sv
// Result stage: register file with two read ports and the writeback register
`timescale 1ns/100ps

module result import procPkg::*; (
	input logic clk,
	input logic rstN,
	input writeT exWrite,
	input regIdxT rsIdx,
	input regIdxT rtIdx,
	output logic [dataWidth-1:0] rsData,
	output logic [dataWidth-1:0] rtData,
	output writeT rfWrite
);

	logic [dataWidth-1:0] regs [regCount];

	// All registers read zero after reset
	always_ff @(posedge clk) begin
		if (!rstN)
			regs <= '{default: '0};
		else if (exWrite.valid)
			regs[exWrite.dest] <= exWrite.data;
	end

	// Asynchronous reads, same-edge writes come in through forwarding
	assign rsData = regs[rsIdx];
	assign rtData = regs[rtIdx];

	// One-cycle writeback pulse to the outside
	always_ff @(posedge clk) begin
		rfWrite.dest <= exWrite.dest;
		rfWrite.data <= exWrite.data;
		if (!rstN)
			rfWrite.valid <= 1'b0;
		else
			rfWrite.valid <= exWrite.valid;
	end

endmodule

//--- project.f
logic/procPkg.sv
logic/decode.sv
logic/execute.sv
logic/result.sv
logic/proc.sv
verification/procAsserts.sv
verification/procTb.sv

//--- verification/procAsserts.sv
// Concurrent checks on the pipeline top level's writeback and error ports
`timescale 1ns/100ps

module procAsserts (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input logic wbValid,
	input logic err
);

	wbKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(wbValid))
		else $error("wbValid is unknown after reset");

	// Error pulse follows the sampled illegal word by one cycle
	errCause: assert property (@(posedge clk) disable iff (!rstN) err |-> $past(instrValid))
		else $error("err without a valid instruction one cycle earlier");

	// Three-stage latency from sample to writeback
	wbCause: assert property (@(posedge clk) disable iff (!rstN)
		wbValid |-> $past(instrValid, 3))
		else $error("wbValid without a valid instruction three cycles earlier");

	quietAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !wbValid && !err)
		else $error("wbValid or err high in the first cycle after reset");

endmodule

bind proc procAsserts i_asserts (
	.clk(clk),
	.rstN(rstN),
	.instrValid(instrValid),
	.wbValid(wbValid),
	.err(err)
);

//--- verification/procTb.sv
// Testbench for the pipeline: seeded random instruction stream checked against a reference model
`timescale 1ns/100ps

module procTb import procPkg::*; ();

	localparam int clkPeriod = 40;
	localparam int driveDelay = 2;
	localparam int numInstr = 600;
	localparam int watchdogNs = (numInstr * 2 + 50) * clkPeriod;

	// One expected writeback, with the cycle it must show up in
	typedef struct packed {
		int cycle;
		int seq;
		regIdxT dest;
		logic [dataWidth-1:0] data;
	} expWriteT;

	logic clk = 1'b0;
	logic rstN;
	logic instrValid;
	instrT instr;
	logic wbValid;
	regIdxT wbReg;
	logic [dataWidth-1:0] wbData;
	logic err;

	int cycleCount = 0;
	logic [dataWidth-1:0] modelRegs [regCount];
	regIdxT recentDest [3];
	logic [4:0] legalOps [7] = '{opAddi, opSubi, opXori, opAndni, opArith, opShift, opSet};
	expWriteT writeQ [$];
	int errQ [$];
	expWriteT gotWrite;
	int errCycle;

	proc i_dut (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.err(err)
	);

	always #(clkPeriod / 2) clk = ~clk;

	always @(posedge clk)
		cycleCount <= cycleCount + 1;

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
			failRun($sformatf("Error: %s expected 0x%0h actual 0x%0h",
				testName, expected, actual));
	endtask

	// Reference semantics; s is the rs value, t the rt value
	function automatic logic [dataWidth-1:0] modelResult(input logic [4:0] op,
		input functT fn, input logic [dataWidth-1:0] s, input logic [dataWidth-1:0] t,
		input logic [immWidth-1:0] imm);
		logic [dataWidth-1:0] sx;
		logic [dataWidth-1:0] zx;
		int n;
		sx = {{(dataWidth - immWidth){imm[immWidth-1]}}, imm};
		zx = {{(dataWidth - immWidth){1'b0}}, imm};
		n = t[3:0];
		case (op)
			opAddi: return s + sx;
			opSubi: return sx - s;
			opXori: return s ^ zx;
			opAndni: return s & ~zx;
			opArith: case (fn)
				fnAdd: return s + t;
				fnSub: return t - s;
				fnXor: return s ^ t;
				default: return s & ~t;
			endcase
			opShift: case (fn)
				fnRol: return (s << n) | (s >> (dataWidth - n));
				fnSll: return s << n;
				fnRor: return (s >> n) | (s << (dataWidth - n));
				default: return s >> n;
			endcase
			opSet: case (fn)
				fnSeq: return s == t;
				fnSlt: return $signed(s) < $signed(t);
				fnSle: return $signed(s) <= $signed(t);
				default: return (int'(s) + int'(t)) > 32'hffff;
			endcase
			default: return '0;
		endcase
	endfunction

	// Drives one slot: idle, illegal or legal, and updates the model
	task automatic driveRandom(input int seq);
		int roll;
		logic [4:0] op;
		functT fn;
		regIdxT s;
		regIdxT t;
		regIdxT d;
		logic [immWidth-1:0] imm;
		logic [dataWidth-1:0] word;
		logic [dataWidth-1:0] value;
		roll = $urandom_range(99);
		word = $urandom;
		s = $urandom;
		t = $urandom;
		d = $urandom;
		fn = $urandom;
		imm = $urandom;
		// Favour reading a recent destination to exercise forwarding
		if ($urandom_range(1))
			s = recentDest[$urandom_range(2)];
		if ($urandom_range(1))
			t = recentDest[$urandom_range(2)];
		if (roll < 12) begin
			instrValid = 1'b0;
			instr = word;
		end else if (roll < 17) begin
			do
				op = $urandom;
			while (op inside {opAddi, opSubi, opXori, opAndni, opArith, opShift, opSet});
			instrValid = 1'b1;
			instr = {op, word[10:0]};
			errQ.push_back(cycleCount + 1);
		end else begin
			op = legalOps[$urandom_range(6)];
			instrValid = 1'b1;
			if (op inside {opAddi, opSubi, opXori, opAndni})
				instr = {op, s, d, imm};
			else
				instr = {op, s, t, d, fn};
			value = modelResult(op, fn, modelRegs[s], modelRegs[t], imm);
			modelRegs[d] = value;
			writeQ.push_back('{cycleCount + 3, seq, d, value});
			recentDest = '{d, recentDest[0], recentDest[1]};
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk) begin
		if (rstN) begin
			if (wbValid) begin
				if (writeQ.size() == 0) begin
					failRun("Writeback seen with no instruction outstanding");
				end else begin
					gotWrite = writeQ.pop_front();
					checkValue($sformatf("writeback cycle of instruction %0d", gotWrite.seq),
						gotWrite.cycle, cycleCount);
					checkValue($sformatf("writeback register of instruction %0d", gotWrite.seq),
						gotWrite.dest, wbReg);
					checkValue($sformatf("writeback data of instruction %0d", gotWrite.seq),
						gotWrite.data, wbData);
				end
			end else if (writeQ.size() > 0 && writeQ[0].cycle <= cycleCount) begin
				failRun($sformatf("Writeback of instruction %0d never appeared", writeQ[0].seq));
			end
			if (err) begin
				if (errQ.size() == 0) begin
					failRun("Error pulse seen without an illegal instruction");
				end else begin
					errCycle = errQ.pop_front();
					checkValue("error pulse cycle", errCycle, cycleCount);
				end
			end else if (errQ.size() > 0 && errQ[0] <= cycleCount) begin
				failRun("Expected error pulse for an illegal opcode never appeared");
			end
		end
	end

	initial begin
		#watchdogNs;
		failRun("Timeout: the run did not complete in time");
	end

	initial begin
		void'($urandom(32'h91e1));
		modelRegs = '{default: '0};
		recentDest = '{default: '0};
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		repeat (4) @(posedge clk);
		#driveDelay rstN = 1'b1;
		for (int i = 0; i < numInstr; i++) begin
			@(posedge clk);
			#driveDelay driveRandom(i);
		end
		@(posedge clk);
		#driveDelay instrValid = 1'b0;
		// Pipeline drains in three cycles and the idle tail catches stray pulses
		repeat (6) @(posedge clk);
		if (writeQ.size() == 0 && errQ.size() == 0) begin
			$display("test passed");
			$finish;
		end else begin
			failRun("Expected results are still outstanding at the end of the run");
		end
	end

endmodule
